// ==== build.f ====
+incdir+source
source/pipe_pkg.sv
source/issue_decode.sv
source/hazard_detector.sv
source/execute_unit.sv
source/memory_stage.sv
source/register_writeback.sv
source/interlock_pipeline.sv
sim/interlock_pipeline_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       := interlock_pipeline_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/interlock_pipeline_tb.sv ====
/*
  Directed tests for the interlocked pipeline slice. The bus model answers
  each request after 1 to 6 cycles and keeps 256 words, indexed by the low
  address byte. The expected results come from an in-order register model.
*/
`timescale 1ns/10ps
`include "pipe_settings.svh"

module interlock_pipeline_tb;
  import pipe_pkg::*;

  localparam int DW    = `PIPE_DATA_WIDTH;
  localparam int IDX_W = `PIPE_IDX_WIDTH;
  localparam int IMM_W = `PIPE_IMM_WIDTH;
  // About 120 instructions at up to 8 cycles plus MUL latency, plus drains
  localparam int TIMEOUT_CYCLES = 4000;

  typedef struct packed {
    logic          we;
    logic [DW-1:0] addr;
    logic [DW-1:0] wdata;
  } bus_op_t;

  logic             clk;
  logic             reset;
  logic             instr_valid;
  instr_word_t      instr;
  logic             stall;
  logic             mem_req;
  logic             mem_we;
  logic [DW-1:0]    mem_addr;
  logic [DW-1:0]    mem_wdata;
  logic             mem_ack;
  logic [DW-1:0]    mem_rdata;
  logic             wb_valid;
  logic [IDX_W-1:0] wb_idx;
  logic [DW-1:0]    wb_data;

  logic [DW-1:0]    ref_regs [`PIPE_REG_COUNT];
  logic [DW-1:0]    ref_mem [256];
  logic [DW-1:0]    mem [256];
  result_t          exp_wr [$];
  bus_op_t          bus_q [$];
  logic             mem_busy;
  int               cycles;

  interlock_pipeline dut0 (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .stall       (stall),
    .mem_req     (mem_req),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata),
    .wb_valid    (wb_valid),
    .wb_idx      (wb_idx),
    .wb_data     (wb_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      abort_run("Value mismatch");
    end
  endtask

  // Every memory word starts with a value unique to its address
  function automatic logic [DW-1:0] fill_word(int a);
    fill_word = (DW'(a) * 32'h9E37_79B1) ^ 32'h0F1E_2D3C;
  endfunction

  function automatic logic [DW-1:0] sext(logic [IMM_W-1:0] imm);
    sext = {{(DW-IMM_W){imm[IMM_W-1]}}, imm};
  endfunction

  function automatic int rand_imm();
    rand_imm = int'($urandom_range(262143, 0)) - 131072;
  endfunction

  function automatic instr_word_t reg_instr(opcode_t op, int rd, int rs1, int rs2);
    instr_word_t w;
    w = '0;
    w.reg_form.op  = op;
    w.reg_form.rd  = IDX_W'(rd);
    w.reg_form.rs1 = IDX_W'(rs1);
    w.reg_form.rs2 = IDX_W'(rs2);
    return w;
  endfunction

  function automatic instr_word_t imm_instr(opcode_t op, int rd, int rs1, int imm);
    instr_word_t w;
    w = '0;
    w.imm_form.op  = op;
    w.imm_form.rd  = IDX_W'(rd);
    w.imm_form.rs1 = IDX_W'(rs1);
    w.imm_form.imm = IMM_W'(imm);
    return w;
  endfunction

  // Runs one instruction in program order and records what it must produce
  task automatic model_step(input instr_word_t w);
    logic [DW-1:0] a;
    logic [DW-1:0] b;
    logic [DW-1:0] addr;
    logic [DW-1:0] res;
    logic          writes;
    a      = ref_regs[w.reg_form.rs1];
    b      = ref_regs[w.reg_form.rs2];
    addr   = ref_regs[w.imm_form.rs1] + sext(w.imm_form.imm);
    res    = '0;
    writes = 1'b1;
    case (w.reg_form.op)
      ADD: res = a + b;
      SUB: res = a - b;
      AND: res = a & b;
      OR:  res = a | b;
      XOR: res = a ^ b;
      MUL: res = a * b;
      LI:  res = sext(w.imm_form.imm);
      LOAD:
      begin
        bus_q.push_back({1'b0, addr, 32'h0});
        res = ref_mem[addr[7:0]];
      end
      // Store data comes from the rd field
      STORE:
      begin
        bus_q.push_back({1'b1, addr, ref_regs[w.imm_form.rd]});
        ref_mem[addr[7:0]] = ref_regs[w.imm_form.rd];
        writes = 1'b0;
      end
      default: writes = 1'b0;
    endcase
    // Both forms keep rd in the same bits
    if (writes && w.reg_form.rd != '0)
    begin
      ref_regs[w.reg_form.rd] = res;
      exp_wr.push_back({1'b1, w.reg_form.rd, res});
    end
  endtask

  // Holds the word until it is accepted, returns 1 ns after that edge
  task automatic issue(input instr_word_t w);
    instr_valid = 1'b1;
    instr       = w;
    @(negedge clk);
    while (stall)
      @(negedge clk);
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    model_step(w);
  endtask

  // Oldest pending write of the same register must match
  task automatic match_write(input logic [IDX_W-1:0] idx, input logic [DW-1:0] data);
    int pos;
    int i;
    pos = -1;
    for (i = 0; i < exp_wr.size(); i++)
      if (pos < 0 && exp_wr[i].idx == idx)
        pos = i;
    assert (pos >= 0)
    else
      abort_run($sformatf("Write to register %0d that the program never made", idx));
    if (pos >= 0)
    begin
      check_value($sformatf("wb_data (r%0d)", idx), data, exp_wr[pos].data);
      exp_wr.delete(pos);
    end
  endtask

  always @(negedge clk)
  begin
    if (wb_valid)
      match_write(wb_idx, wb_data);
  end

  // Quiet means ten cycles without writes, bus traffic or stall
  task automatic drain_and_check();
    int idle;
    idle = 0;
    while (idle < 10)
    begin
      @(negedge clk);
      if (wb_valid || mem_req || mem_busy || stall)
        idle = 0;
      else
        idle++;
    end
    @(posedge clk);
    #1;
    assert (exp_wr.size() == 0)
    else
      abort_run($sformatf("%0d expected register writes never arrived", exp_wr.size()));
    assert (bus_q.size() == 0)
    else
      abort_run($sformatf("%0d expected bus accesses never happened", bus_q.size()));
  endtask

  // Bus model with a random acknowledge delay
  initial
  begin
    int      gap;
    int      i;
    bus_op_t exp;
    for (i = 0; i < 256; i++)
      mem[i] = fill_word(i);
    mem_ack   = 1'b0;
    mem_rdata = '0;
    mem_busy  = 1'b0;
    forever
    begin
      @(negedge clk);
      if (mem_req)
      begin
        mem_busy = 1'b1;
        assert (bus_q.size() != 0)
        else
          abort_run("Bus request without a pending load or store");
        exp = bus_q.pop_front();
        check_value("mem_we", DW'(mem_we), DW'(exp.we));
        check_value("mem_addr", mem_addr, exp.addr);
        if (exp.we)
          check_value("mem_wdata", mem_wdata, exp.wdata);
        gap = int'($urandom_range(6, 1));
        repeat (gap) @(posedge clk);
        #1;
        mem_ack = 1'b1;
        if (mem_we)
          mem[mem_addr[7:0]] = mem_wdata;
        else
          mem_rdata = mem[mem_addr[7:0]];
        @(posedge clk);
        #1;
        mem_ack  = 1'b0;
        mem_busy = 1'b0;
      end
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
      abort_run($sformatf("Timeout, run still busy after %0d cycles", cycles));
  end

  task automatic check_reset_state();
    @(negedge clk);
    check_value("stall", DW'(stall), 32'h0);
    check_value("wb_valid", DW'(wb_valid), 32'h0);
    check_value("mem_req", DW'(mem_req), 32'h0);
    @(posedge clk);
    #1;
  endtask

  task automatic run_alu_li();
    int r;
    for (r = 1; r <= 10; r++)
      issue(imm_instr(LI, r, 0, rand_imm()));
    issue(reg_instr(ADD, 11, 1, 2));
    issue(reg_instr(SUB, 12, 3, 4));
    issue(reg_instr(AND, 13, 5, 6));
    issue(reg_instr(OR, 14, 7, 8));
    issue(reg_instr(XOR, 15, 9, 10));
    // Results aimed at register 0 must stay off the wb port
    issue(reg_instr(ADD, 0, 1, 2));
    issue(imm_instr(LI, 0, 0, 123));
    drain_and_check();
  endtask

  task automatic run_raw_chain();
    int n;
    for (n = 0; n < 3; n++)
    begin
      issue(imm_instr(LI, 1, 0, rand_imm()));
      issue(imm_instr(LI, 2, 0, rand_imm()));
      issue(reg_instr(MUL, 3, 1, 2));
      issue(reg_instr(ADD, 4, 3, 1));
      issue(reg_instr(MUL, 5, 4, 4));
      issue(reg_instr(SUB, 6, 5, 3));
      // Reads and rewrites its own destination
      issue(reg_instr(MUL, 6, 6, 2));
      issue(reg_instr(XOR, 7, 6, 5));
    end
    drain_and_check();
  endtask

  task automatic run_load_use();
    int n;
    int off;
    for (n = 0; n < 4; n++)
    begin
      off = int'($urandom_range(50, 0));
      issue(imm_instr(LI, 7, 0, int'($urandom_range(200, 60))));
      issue(imm_instr(LI, 8, 0, rand_imm()));
      // Negative offset exercises the sign extension
      issue(imm_instr(STORE, 8, 7, -off));
      issue(imm_instr(LOAD, 9, 7, -off));
      issue(reg_instr(ADD, 10, 9, 8));
    end
    drain_and_check();
  endtask

  task automatic run_waw_zero();
    int n;
    for (n = 0; n < 2; n++)
    begin
      issue(imm_instr(LOAD, 12, 0, 20 + n));
      issue(imm_instr(LI, 12, 0, rand_imm()));
      issue(reg_instr(ADD, 13, 12, 0));
      issue(reg_instr(ADD, 0, 12, 12));
      issue(reg_instr(OR, 14, 0, 0));
      issue(imm_instr(STORE, 0, 0, 30 + n));
      issue(imm_instr(LOAD, 15, 0, 30 + n));
      issue(imm_instr(LOAD, 0, 0, 34));
      issue(reg_instr(ADD, 16, 0, 15));
    end
    drain_and_check();
  endtask

  // Loads overlap with ALU work and may collide on the write port
  task automatic run_overlap();
    int k;
    for (k = 0; k < 6; k++)
    begin
      issue(imm_instr(LOAD, 20 + (k % 4), 0, 40 + k));
      issue(reg_instr(ADD, 24, 1, 2));
      issue(reg_instr(XOR, 25, 3, 4));
      issue(imm_instr(LI, 26, 0, rand_imm()));
      issue(reg_instr(SUB, 27, 25, 24));
    end
    drain_and_check();
  endtask

  initial
  begin
    int i;
    void'($urandom(65));
    cycles      = 0;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    for (i = 0; i < `PIPE_REG_COUNT; i++)
      ref_regs[i] = '0;
    for (i = 0; i < 256; i++)
      ref_mem[i] = fill_word(i);
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    check_reset_state();
    run_alu_li();
    run_raw_chain();
    run_load_use();
    run_waw_zero();
    run_overlap();
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== source/interlock_pipeline.sv ====
/*
  Top of the interlocked pipeline slice. instr must stay stable while stall
  is high. The memory bus allows one outstanding request.
*/
`timescale 1ns/10ps
`include "pipe_settings.svh"

module interlock_pipeline (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        instr_valid,
  input  pipe_pkg::instr_word_t       instr,
  output logic                        stall,
  output logic                        mem_req,
  output logic                        mem_we,
  output logic [`PIPE_DATA_WIDTH-1:0] mem_addr,
  output logic [`PIPE_DATA_WIDTH-1:0] mem_wdata,
  input  logic                        mem_ack,
  input  logic [`PIPE_DATA_WIDTH-1:0] mem_rdata,
  output logic                        wb_valid,
  output logic [`PIPE_IDX_WIDTH-1:0]  wb_idx,
  output logic [`PIPE_DATA_WIDTH-1:0] wb_data
);
  import pipe_pkg::*;

  logic                        dec_valid;
  decoded_op_t                 dec_op;
  logic [`PIPE_IDX_WIDTH-1:0]  rd_idx1;
  logic [`PIPE_IDX_WIDTH-1:0]  rd_idx2;
  logic [`PIPE_DATA_WIDTH-1:0] rd_data1;
  logic [`PIPE_DATA_WIDTH-1:0] rd_data2;
  logic                        exec_go;
  logic                        mem_go;
  logic                        exec_taken;
  unit_status_t                exec_status;
  unit_status_t                mem_status;
  result_t                     exec_result;
  result_t                     mem_result;

  // Either dispatch pulse empties the decode stage
  issue_decode u_decode (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .stall       (stall),
    .dispatch    (exec_go | mem_go),
    .rd_data1    (rd_data1),
    .rd_data2    (rd_data2),
    .rd_idx1     (rd_idx1),
    .rd_idx2     (rd_idx2),
    .dec_valid   (dec_valid),
    .dec_op      (dec_op)
  );

  hazard_detector u_hazard (
    .dec_valid   (dec_valid),
    .dec_op      (dec_op),
    .exec_status (exec_status),
    .mem_status  (mem_status),
    .stall       (stall),
    .exec_go     (exec_go),
    .mem_go      (mem_go)
  );

  execute_unit u_exec (
    .clk         (clk),
    .reset       (reset),
    .exec_go     (exec_go),
    .dec_op      (dec_op),
    .exec_taken  (exec_taken),
    .exec_status (exec_status),
    .exec_result (exec_result)
  );

  memory_stage u_mem (
    .clk         (clk),
    .reset       (reset),
    .mem_go      (mem_go),
    .dec_op      (dec_op),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata),
    .mem_req     (mem_req),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_status  (mem_status),
    .mem_result  (mem_result)
  );

  register_writeback u_regs (
    .clk         (clk),
    .reset       (reset),
    .rd_idx1     (rd_idx1),
    .rd_idx2     (rd_idx2),
    .exec_result (exec_result),
    .mem_result  (mem_result),
    .rd_data1    (rd_data1),
    .rd_data2    (rd_data2),
    .exec_taken  (exec_taken),
    .wb_valid    (wb_valid),
    .wb_idx      (wb_idx),
    .wb_data     (wb_data)
  );

endmodule

// ==== source/register_writeback.sv ====
/*
  Register file with two combinational read ports and one write port. The
  memory result wins the port; a displaced execute result retries next
  cycle. Writes to register 0 are dropped and never reported.
*/
`timescale 1ns/10ps
`include "pipe_settings.svh"

module register_writeback (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`PIPE_IDX_WIDTH-1:0]  rd_idx1,
  input  logic [`PIPE_IDX_WIDTH-1:0]  rd_idx2,
  input  pipe_pkg::result_t           exec_result,
  input  pipe_pkg::result_t           mem_result,
  output logic [`PIPE_DATA_WIDTH-1:0] rd_data1,
  output logic [`PIPE_DATA_WIDTH-1:0] rd_data2,
  output logic                        exec_taken,
  output logic                        wb_valid,
  output logic [`PIPE_IDX_WIDTH-1:0]  wb_idx,
  output logic [`PIPE_DATA_WIDTH-1:0] wb_data
);
  import pipe_pkg::*;

  logic [`PIPE_DATA_WIDTH-1:0] regs [`PIPE_REG_COUNT];
  result_t                     sel;

  // Memory first, execute otherwise
  always_comb
  begin
    sel        = mem_result.valid ? mem_result : exec_result;
    // A result to register 0 is still taken so the unit frees up
    exec_taken = exec_result.valid && !mem_result.valid;
    wb_valid   = sel.valid && (sel.idx != '0);
  end

  assign wb_idx  = sel.idx;
  assign wb_data = sel.data;

  // Entry 0 is cleared here and never written, so it reads as zero
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `PIPE_REG_COUNT; i++)
        regs[i] <= '0;
    end
    else if (wb_valid)
      regs[sel.idx] <= sel.data;
  end

  // Reads see the old value during a write to the same register
  assign rd_data1 = regs[rd_idx1];
  assign rd_data2 = regs[rd_idx2];

endmodule

// ==== source/memory_stage.sv ====
/*
  Load and store over a strobe bus with word addresses. One request is
  outstanding at a time, and mem_ack is only sampled from the cycle after
  mem_req. A load result is shown for exactly one cycle.
*/
`timescale 1ns/10ps
`include "pipe_settings.svh"

module memory_stage (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         mem_go,
  input  pipe_pkg::decoded_op_t        dec_op,
  input  logic                         mem_ack,
  input  logic [`PIPE_DATA_WIDTH-1:0]  mem_rdata,
  output logic                         mem_req,
  output logic                         mem_we,
  output logic [`PIPE_DATA_WIDTH-1:0]  mem_addr,
  output logic [`PIPE_DATA_WIDTH-1:0]  mem_wdata,
  output pipe_pkg::unit_status_t       mem_status,
  output pipe_pkg::result_t            mem_result
);
  import pipe_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_DONE} mem_state_t;

  mem_state_t                  state;
  logic                        we_q;
  logic [`PIPE_IDX_WIDTH-1:0]  dst_q;
  logic [`PIPE_DATA_WIDTH-1:0] addr_q;
  logic [`PIPE_DATA_WIDTH-1:0] wdata_q;
  logic [`PIPE_DATA_WIDTH-1:0] rdata_q;

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= S_IDLE;
    else
    begin
      case (state)
        S_IDLE: if (mem_go) state <= S_REQ;
        S_REQ:  state <= S_WAIT;
        // Stores finish at the acknowledge
        S_WAIT: if (mem_ack) state <= we_q ? S_IDLE : S_DONE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (mem_go)
    begin
      we_q    <= (dec_op.op == STORE);
      dst_q   <= dec_op.rd;
      addr_q  <= dec_op.val1 + dec_op.imm;
      wdata_q <= dec_op.val2;
    end
    if (state == S_WAIT && mem_ack)
      rdata_q <= mem_rdata;
  end

  // Request pulse in the cycle after mem_go
  assign mem_req   = (state == S_REQ);
  assign mem_we    = we_q;
  assign mem_addr  = addr_q;
  assign mem_wdata = wdata_q;

  // A store carries destination 0 and blocks only through busy
  assign mem_status.busy  = (state != S_IDLE);
  assign mem_status.dst   = dst_q;
  assign mem_result.valid = (state == S_DONE);
  assign mem_result.idx   = dst_q;
  assign mem_result.data  = rdata_q;

endmodule

// ==== source/execute_unit.sv ====
/*
  Single-issue execute unit. ALU and LI results are valid the cycle after
  dispatch, MUL after PIPE_MUL_CYCLES cycles. The result is held until the
  write port takes it, and the unit reports busy for that whole time.
*/
`timescale 1ns/10ps
`include "pipe_settings.svh"

module execute_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  exec_go,
  input  pipe_pkg::decoded_op_t dec_op,
  input  logic                  exec_taken,
  output pipe_pkg::unit_status_t exec_status,
  output pipe_pkg::result_t     exec_result
);
  import pipe_pkg::*;

  localparam int CNT_W = $clog2(`PIPE_MUL_CYCLES + 1);

  logic [`PIPE_DATA_WIDTH-1:0] alu_out;
  logic                        valid_q;
  logic [CNT_W-1:0]            cnt_q;
  logic [`PIPE_IDX_WIDTH-1:0]  dst_q;
  logic [`PIPE_DATA_WIDTH-1:0] data_q;
  logic [`PIPE_DATA_WIDTH-1:0] mul_a;
  logic [`PIPE_DATA_WIDTH-1:0] mul_b;

  // Single-cycle operations
  always_comb
  begin
    case (dec_op.op)
      ADD:     alu_out = dec_op.val1 + dec_op.val2;
      SUB:     alu_out = dec_op.val1 - dec_op.val2;
      AND:     alu_out = dec_op.val1 & dec_op.val2;
      OR:      alu_out = dec_op.val1 | dec_op.val2;
      XOR:     alu_out = dec_op.val1 ^ dec_op.val2;
      LI:      alu_out = dec_op.imm;
      default: alu_out = '0;
    endcase
  end

  // MUL counts down and turns valid as the count leaves 1
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end
    else if (exec_go)
    begin
      valid_q <= (dec_op.op != MUL);
      cnt_q   <= (dec_op.op == MUL) ? CNT_W'(`PIPE_MUL_CYCLES - 1) : '0;
    end
    else if (cnt_q != '0)
    begin
      cnt_q <= cnt_q - 1'b1;
      if (cnt_q == CNT_W'(1))
        valid_q <= 1'b1;
    end
    else if (valid_q && exec_taken)
      valid_q <= 1'b0;
  end

  // Operands are captured at dispatch and the product lands at the end
  always_ff @(posedge clk)
  begin
    if (exec_go)
    begin
      dst_q  <= dec_op.rd;
      data_q <= alu_out;
      mul_a  <= dec_op.val1;
      mul_b  <= dec_op.val2;
    end
    else if (cnt_q == CNT_W'(1))
      data_q <= mul_a * mul_b;
  end

  // Busy from dispatch until the result is taken
  assign exec_status.busy  = valid_q || (cnt_q != '0);
  assign exec_status.dst   = dst_q;
  assign exec_result.valid = valid_q;
  assign exec_result.idx   = dst_q;
  assign exec_result.data  = data_q;

endmodule

// ==== source/hazard_detector.sv ====
/*
  Interlock on the decode stage. Covers RAW and WAW against both units and
  busy units; a unit reporting destination 0 never blocks. Purely
  combinational, so stall and the dispatch pulses settle in one cycle.
*/
`timescale 1ns/10ps

module hazard_detector (
  input  logic                   dec_valid,
  input  pipe_pkg::decoded_op_t  dec_op,
  input  pipe_pkg::unit_status_t exec_status,
  input  pipe_pkg::unit_status_t mem_status,
  output logic                   stall,
  output logic                   exec_go,
  output logic                   mem_go
);
  import pipe_pkg::*;

  logic needs_exec;
  logic needs_mem;
  logic exec_conflict;
  logic mem_conflict;
  logic structural;
  logic blocked;

  // Sources give RAW, the destination gives WAW
  function automatic logic touches(decoded_op_t op, unit_status_t st);
    touches = st.busy && (st.dst != '0) &&
              ((op.rs1 == st.dst) || (op.rs2 == st.dst) || (op.rd == st.dst));
  endfunction

  always_comb
  begin
    needs_mem     = (dec_op.op == LOAD) || (dec_op.op == STORE);
    needs_exec    = !needs_mem && (dec_op.op != NOP);
    // Store data source is rs2, so store-use is a plain RAW here
    exec_conflict = touches(dec_op, exec_status);
    mem_conflict  = touches(dec_op, mem_status);
    // Each unit takes one operation at a time
    structural    = (needs_exec && exec_status.busy) || (needs_mem && mem_status.busy);
    blocked       = exec_conflict || mem_conflict || structural;
    stall         = dec_valid && blocked;
    exec_go       = dec_valid && !blocked && needs_exec;
    mem_go        = dec_valid && !blocked && needs_mem;
  end

endmodule

// ==== source/issue_decode.sv ====
/*
  Decode stage holding one instruction. Source operands are read from the
  register file in every cycle the stage is full, so a value written while
  the instruction waits is picked up before dispatch.
*/
`timescale 1ns/10ps
`include "pipe_settings.svh"

module issue_decode (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        instr_valid,
  input  pipe_pkg::instr_word_t       instr,
  input  logic                        stall,
  input  logic                        dispatch,
  input  logic [`PIPE_DATA_WIDTH-1:0] rd_data1,
  input  logic [`PIPE_DATA_WIDTH-1:0] rd_data2,
  output logic [`PIPE_IDX_WIDTH-1:0]  rd_idx1,
  output logic [`PIPE_IDX_WIDTH-1:0]  rd_idx2,
  output logic                        dec_valid,
  output pipe_pkg::decoded_op_t       dec_op
);
  import pipe_pkg::*;

  logic                        accept;
  opcode_t                     nxt_op;
  logic [`PIPE_IDX_WIDTH-1:0]  nxt_rd;
  logic [`PIPE_IDX_WIDTH-1:0]  nxt_rs1;
  logic [`PIPE_IDX_WIDTH-1:0]  nxt_rs2;
  logic [`PIPE_DATA_WIDTH-1:0] nxt_imm;
  opcode_t                     op_q;
  logic [`PIPE_IDX_WIDTH-1:0]  rd_q;
  logic [`PIPE_IDX_WIDTH-1:0]  rs1_q;
  logic [`PIPE_IDX_WIDTH-1:0]  rs2_q;
  logic [`PIPE_DATA_WIDTH-1:0] imm_q;

  // Stall is only high while the stage is full and blocked
  assign accept = instr_valid && !stall;

  // Field selection follows the form named by the opcode
  always_comb
  begin
    nxt_op  = instr.reg_form.op;
    nxt_rd  = '0;
    nxt_rs1 = '0;
    nxt_rs2 = '0;
    nxt_imm = {{(`PIPE_DATA_WIDTH-`PIPE_IMM_WIDTH){instr.imm_form.imm[`PIPE_IMM_WIDTH-1]}},
               instr.imm_form.imm};
    case (instr.reg_form.op)
      ADD, SUB, AND, OR, XOR, MUL:
      begin
        nxt_rd  = instr.reg_form.rd;
        nxt_rs1 = instr.reg_form.rs1;
        nxt_rs2 = instr.reg_form.rs2;
      end
      LI:
        nxt_rd  = instr.imm_form.rd;
      LOAD:
      begin
        nxt_rd  = instr.imm_form.rd;
        nxt_rs1 = instr.imm_form.rs1;
      end
      // Store data rides on the second read port
      STORE:
      begin
        nxt_rs1 = instr.imm_form.rs1;
        nxt_rs2 = instr.imm_form.rd;
      end
      // NOP and undefined opcodes touch no register
      default:
        nxt_op  = NOP;
    endcase
  end

  // A NOP leaves the stage without a dispatch pulse
  always_ff @(posedge clk)
  begin
    if (reset)
      dec_valid <= 1'b0;
    else if (accept)
      dec_valid <= 1'b1;
    else if (dispatch || op_q == NOP)
      dec_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      op_q  <= nxt_op;
      rd_q  <= nxt_rd;
      rs1_q <= nxt_rs1;
      rs2_q <= nxt_rs2;
      imm_q <= nxt_imm;
    end
  end

  assign rd_idx1 = rs1_q;
  assign rd_idx2 = rs2_q;

  always_comb
  begin
    dec_op.op   = op_q;
    dec_op.rd   = rd_q;
    dec_op.rs1  = rs1_q;
    dec_op.rs2  = rs2_q;
    dec_op.val1 = rd_data1;
    dec_op.val2 = rd_data2;
    dec_op.imm  = imm_q;
  end

endmodule

// ==== source/pipe_pkg.sv ====
/*
  Types shared by the pipeline stages. Opcode values above STORE are
  undefined and are decoded as NOP.
*/
`include "pipe_settings.svh"

package pipe_pkg;

  // Opcode sits in the top four bits of every instruction
  typedef enum logic [3:0] {
    NOP   = 4'd0,
    ADD   = 4'd1,
    SUB   = 4'd2,
    AND   = 4'd3,
    OR    = 4'd4,
    XOR   = 4'd5,
    MUL   = 4'd6,
    LI    = 4'd7,
    LOAD  = 4'd8,
    STORE = 4'd9
  } opcode_t;

  // Register form for NOP, ALU ops and MUL
  typedef struct packed {
    opcode_t                                           op;
    logic [`PIPE_IDX_WIDTH-1:0]                        rd;
    logic [`PIPE_IDX_WIDTH-1:0]                        rs1;
    logic [`PIPE_IDX_WIDTH-1:0]                        rs2;
    logic [`PIPE_DATA_WIDTH-4-3*`PIPE_IDX_WIDTH-1:0]   pad;
  } reg_form_t;

  // Immediate form for LI, LOAD and STORE
  // For STORE the rd field names the data source
  typedef struct packed {
    opcode_t                    op;
    logic [`PIPE_IDX_WIDTH-1:0] rd;
    logic [`PIPE_IDX_WIDTH-1:0] rs1;
    logic [`PIPE_IMM_WIDTH-1:0] imm;
  } imm_form_t;

  typedef union packed {
    reg_form_t reg_form;
    imm_form_t imm_form;
  } instr_word_t;

  // Decode stage contents, unused indices are zero
  typedef struct packed {
    opcode_t                     op;
    logic [`PIPE_IDX_WIDTH-1:0]  rd;
    logic [`PIPE_IDX_WIDTH-1:0]  rs1;
    logic [`PIPE_IDX_WIDTH-1:0]  rs2;
    logic [`PIPE_DATA_WIDTH-1:0] val1;
    logic [`PIPE_DATA_WIDTH-1:0] val2;
    logic [`PIPE_DATA_WIDTH-1:0] imm;
  } decoded_op_t;

  // Unit result toward the write port
  typedef struct packed {
    logic                        valid;
    logic [`PIPE_IDX_WIDTH-1:0]  idx;
    logic [`PIPE_DATA_WIDTH-1:0] data;
  } result_t;

  // Occupancy and pending destination of a unit
  typedef struct packed {
    logic                       busy;
    logic [`PIPE_IDX_WIDTH-1:0] dst;
  } unit_status_t;

endpackage

// ==== source/pipe_settings.svh ====
/*
  Build-time sizes of the pipeline slice. Both instruction forms must total
  PIPE_DATA_WIDTH bits, so PIPE_IMM_WIDTH is tied to the index width.
  PIPE_MUL_CYCLES must be at least 2.
*/
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// Register and data path width
`define PIPE_DATA_WIDTH 32

// Architectural registers, entry 0 reads as zero
`define PIPE_REG_COUNT 32
`define PIPE_IDX_WIDTH $clog2(`PIPE_REG_COUNT)

// Cycles from MUL dispatch to a valid result
`define PIPE_MUL_CYCLES 3

// Signed immediate of LI, LOAD and STORE
`define PIPE_IMM_WIDTH 18

`endif
